/* Makefile */
# Verilator build and run for the gcd unit
# override any variable on the command line, e.g. make sim TOP=gcd_tb

VERILATOR ?= verilator
TOP       ?= gcd_tb
FLIST     ?= gcd_unit.f
VFLAGS    ?= --assert --timescale 1ns/100ps

.PHONY: sim clean

# build, run, and pass only if the testbench printed its pass line
sim:
	$(VERILATOR) --binary --timing $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf obj_dir

/* include/gcd_tb_ref.svh */
/* reference model helpers for the gcd testbench
   included inside the testbench module after gcd_pkg is imported */

`ifndef GCD_TB_REF_SVH
`define GCD_TB_REF_SVH

// euclid by subtraction, gcd(x,0) = x and gcd(0,0) = 0
function automatic gcd_operand_t ref_gcd(input gcd_operand_t a, input gcd_operand_t b);
  gcd_operand_t x;
  gcd_operand_t y;
  gcd_operand_t t;
  x = a;
  y = b;
  while (y != '0) begin
    if (x < y) begin
      t = x;
      x = y;
      y = t;
    end else begin
      x = x - y;
    end
  end
  return x;
endfunction

// xorshift32 step, state must never be zero
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] r;
  r = s ^ (s << 13);
  r = r ^ (r >> 17);
  r = r ^ (r << 5);
  return r;
endfunction

`endif

/* bench/gcd_tb.sv */
/* testbench for the gcd unit, drives fixed, zero and random operand pairs
   and checks every response against the reference model in the header */

`timescale 1ns/100ps

module gcd_tb
  import gcd_pkg::*;
();

  `include "gcd_tb_ref.svh"

  localparam logic [31:0]  SEED          = 32'h10a0_51d4;
  localparam int           N_RANDOM      = 200;
  localparam gcd_operand_t RAND_MASK     = 16'h00ff;   // 8-bit random operands
  localparam int           RESET_CYCLES  = 8;
  localparam int           CLK_HALF      = 20;
  localparam int           DRIVE_DLY     = 2;
  localparam int           PAIR_OVERHEAD = 10;         // handshake and stalls

  logic         clk;
  logic         clk_reset;
  logic         req_val;
  logic         req_rdy;
  gcd_req_t     req;
  logic         resp_val;
  logic         resp_rdy;
  gcd_resp_t    resp;

  // test list and outstanding expectations
  gcd_operand_t list_a[$];
  gcd_operand_t list_b[$];
  gcd_operand_t exp_q[$];
  gcd_req_t     op_q[$];

  logic [31:0]  rng;
  int           errors;
  int           n_req;
  int           n_resp;
  int           cycles;
  int           cycle_limit;
  logic         stall_en;

  gcd_unit UUT (
    .clk       (clk),
    .clk_reset (clk_reset),
    .req_val   (req_val),
    .req_rdy   (req_rdy),
    .req       (req),
    .resp_val  (resp_val),
    .resp_rdy  (resp_rdy),
    .resp      (resp)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------

  task automatic add_pair(input gcd_operand_t a, input gcd_operand_t b);
    list_a.push_back(a);
    list_b.push_back(b);
  endtask

  // entered just after a rising edge, leaves just after the accepting edge
  task automatic send_pair(input gcd_operand_t a, input gcd_operand_t b);
    req_val = 1'b1;
    req.a   = a;
    req.b   = b;
    @(negedge clk);
    while (!req_rdy) @(negedge clk);
    // transfer happens on the coming edge
    exp_q.push_back(ref_gcd(a, b));
    op_q.push_back(req);
    n_req++;
    @(posedge clk);
    #DRIVE_DLY;
    req_val = 1'b0;
    req     = '0;
  endtask

  // --------------------------------------------------------------------------
  // consumer back-pressure, about one cycle in four when enabled
  // --------------------------------------------------------------------------

  initial begin
    resp_rdy = 1'b1;
    forever begin
      @(posedge clk);
      #DRIVE_DLY;
      if (stall_en) begin
        rng      = xorshift32(rng);
        resp_rdy = (rng[1:0] != 2'b00);
      end else begin
        resp_rdy = 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // checker, samples mid-cycle where everything is settled
  // --------------------------------------------------------------------------

  initial begin
    gcd_operand_t exp_val;
    gcd_req_t     op;
    logic         in_flight;
    logic         held_prev;
    gcd_resp_t    resp_prev;
    in_flight = 1'b0;
    held_prev = 1'b0;
    resp_prev = '0;
    forever begin
      @(negedge clk);
      if (!clk_reset) begin
        // stalled result must stay offered
        if (held_prev && resp_val !== 1'b1) begin
          errors++;
          $display("FAILED %0t: resp_val dropped under back-pressure", $time);
        end
        // stalled result must not move
        if (held_prev && resp_val && resp !== resp_prev) begin
          errors++;
          $display("FAILED %0t: resp moved under back-pressure %0d -> %0d",
                   $time, resp_prev, resp);
        end
        if (in_flight && req_rdy) begin
          errors++;
          $display("FAILED %0t: req_rdy high with a request in flight", $time);
        end
        if (req_val && req_rdy) begin
          in_flight = 1'b1;
        end
        if (resp_val && resp_rdy) begin
          n_resp++;
          in_flight = 1'b0;
          if (exp_q.size() == 0) begin
            errors++;
            $display("response taken at %0t with no request outstanding", $time);
          end else begin
            exp_val = exp_q.pop_front();
            op      = op_q.pop_front();
            if (resp !== exp_val) begin
              errors++;
              $display("FAILED %0t: gcd(%0d,%0d) gave %0d, expected %0d",
                       $time, op.a, op.b, resp, exp_val);
            end
          end
        end
        held_prev = resp_val && !resp_rdy;
        resp_prev = resp;
      end
    end
  end

  // timeout, limit is set at time zero from the test list
  initial begin
    cycles = 0;
    #1;
    while (cycles <= cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("run stopped after %0d cycles, only %0d of %0d responses seen",
             cycles, n_resp, list_a.size());
    $display("TEST FAILED");
    $finish;
  end

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------

  initial begin
    gcd_operand_t ra;
    gcd_operand_t rb;
    gcd_operand_t mx;
    int           n_fixed;
    rng       = SEED;
    errors    = 0;
    n_req     = 0;
    n_resp    = 0;
    stall_en  = 1'b0;
    clk_reset = 1'b1;
    req_val   = 1'b0;
    req       = '0;

    // reference vectors, then zero operands
    add_pair(16'd15, 16'd10);
    add_pair(16'd22, 16'd10);
    add_pair(16'd36, 16'd18);
    add_pair(16'd36, 16'd21);
    add_pair(16'd0, 16'd0);
    add_pair(16'd0, 16'd7);
    add_pair(16'd9, 16'd0);
    n_fixed = list_a.size();
    for (int i = 0; i < N_RANDOM; i++) begin
      rng = xorshift32(rng);
      ra  = rng[15:0] & RAND_MASK;
      rng = xorshift32(rng);
      rb  = rng[15:0] & RAND_MASK;
      add_pair(ra, rb);
    end

    // worst case steps per pair stay under twice the larger operand
    cycle_limit = RESET_CYCLES;
    foreach (list_a[i]) begin
      mx          = (list_a[i] > list_b[i]) ? list_a[i] : list_b[i];
      cycle_limit += 2 * int'(mx) + PAIR_OVERHEAD;
    end

    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    clk_reset = 1'b0;

    // idle outputs before any request
    @(negedge clk);
    if (req_rdy !== 1'b1 || resp_val !== 1'b0) begin
      errors++;
      $display("FAILED %0t: after reset req_rdy=%b resp_val=%b",
               $time, req_rdy, resp_val);
    end
    @(posedge clk);
    #DRIVE_DLY;

    for (int i = 0; i < n_fixed; i++) begin
      send_pair(list_a[i], list_b[i]);
    end
    stall_en = 1'b1;
    for (int i = n_fixed; i < list_a.size(); i++) begin
      send_pair(list_a[i], list_b[i]);
    end

    // drain the last response
    while (n_resp < n_req) @(negedge clk);
    if (n_req != list_a.size() || n_resp != n_req || exp_q.size() != 0) begin
      errors++;
      $display("request and response counts do not match at the end");
    end

    $display("errors %0d, requests %0d, responses %0d", errors, n_req, n_resp);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* gcd_unit.f */
+incdir+include
src/gcd_pkg.sv
src/gcd_ctrl.sv
src/gcd_dpath.sv
src/gcd_unit.sv
bench/gcd_tb.sv

/* src/gcd_ctrl.sv */
/* control FSM of the gcd unit
   runs the request/response handshake and steers the datapath muxes */

`timescale 1ns/100ps

module gcd_ctrl
  import gcd_pkg::*;
(
  input  logic              clk,
  input  logic              clk_reset,

  // request channel
  input  logic              req_val,
  output logic              req_rdy,

  // response channel
  output logic              resp_val,
  input  logic              resp_rdy,

  // datapath link
  input  gcd_dpath_status_t dpath_status,
  output gcd_dpath_ctrl_t   dpath_ctrl
);

  gcd_state_e state;
  gcd_state_e state_next;

  //--------------------------------------------------------------------------
  // state register
  //--------------------------------------------------------------------------

  always_ff @(posedge clk or posedge clk_reset) begin
    if (clk_reset) begin
      state <= GCD_IDLE;
    end else begin
      state <= state_next;
    end
  end

  //--------------------------------------------------------------------------
  // transitions
  //--------------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      // wait for a request
      GCD_IDLE: begin
        if (req_val && req_rdy) begin
          state_next = GCD_CALC;
        end
      end
      // finished once b hits zero and no swap is pending
      GCD_CALC: begin
        if (!dpath_status.a_lt_b && dpath_status.b_zero) begin
          state_next = GCD_DONE;
        end
      end
      // hold result until consumer takes it
      GCD_DONE: begin
        if (resp_val && resp_rdy) begin
          state_next = GCD_IDLE;
        end
      end
      default: begin
        state_next = GCD_IDLE;
      end
    endcase
  end

  //--------------------------------------------------------------------------
  // outputs, combinational from state and status
  //--------------------------------------------------------------------------

  always_comb begin
    req_rdy    = 1'b0;
    resp_val   = 1'b0;
    dpath_ctrl = '0;
    case (state)
      GCD_IDLE: begin
        // load both operands every idle cycle, the accepting edge sticks
        req_rdy          = 1'b1;
        dpath_ctrl.a_sel = A_SEL_IN;
        dpath_ctrl.a_en  = 1'b1;
        dpath_ctrl.b_sel = B_SEL_IN;
        dpath_ctrl.b_en  = 1'b1;
      end
      GCD_CALC: begin
        // swap when a < b, else subtract
        dpath_ctrl.a_sel = dpath_status.a_lt_b ? A_SEL_B : A_SEL_SUB;
        dpath_ctrl.a_en  = 1'b1;
        dpath_ctrl.b_sel = B_SEL_A;
        dpath_ctrl.b_en  = dpath_status.a_lt_b;
      end
      GCD_DONE: begin
        // registers frozen so resp stays put
        resp_val = 1'b1;
      end
      default: begin
        resp_val = 1'b0;
      end
    endcase
  end

  //--------------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------------

  // one item in flight, never accepting while offering a result
  a_one_in_flight: assert property (@(posedge clk) disable iff (clk_reset)
    !(req_rdy && resp_val));

  // stalled response is not withdrawn
  a_resp_held: assert property (@(posedge clk) disable iff (clk_reset)
    (resp_val && !resp_rdy) |=> resp_val);

endmodule

/* src/gcd_dpath.sv */
/* datapath of the gcd unit
   operand registers with their muxes, the subtractor and the comparators */

`timescale 1ns/100ps

module gcd_dpath
  import gcd_pkg::*;
(
  input  logic              clk,
  input  logic              clk_reset,

  // request operands
  input  gcd_req_t          req,

  // fsm link
  input  gcd_dpath_ctrl_t   dpath_ctrl,
  output gcd_dpath_status_t dpath_status,

  // result
  output gcd_resp_t         resp
);

  gcd_operand_t a_reg;
  gcd_operand_t b_reg;
  gcd_operand_t a_next;
  gcd_operand_t b_next;
  gcd_operand_t sub_out;

  //--------------------------------------------------------------------------
  // input muxes
  //--------------------------------------------------------------------------

  always_comb begin
    case (dpath_ctrl.a_sel)
      A_SEL_IN:  a_next = req.a;
      A_SEL_SUB: a_next = sub_out;
      A_SEL_B:   a_next = b_reg;
      default:   a_next = a_reg;
    endcase
  end

  // b only ever takes the request or the old a
  always_comb begin
    case (dpath_ctrl.b_sel)
      B_SEL_IN: b_next = req.b;
      default:  b_next = a_reg;
    endcase
  end

  //--------------------------------------------------------------------------
  // operand registers
  //--------------------------------------------------------------------------

  always_ff @(posedge clk or posedge clk_reset) begin
    if (clk_reset) begin
      a_reg <= '0;
    end else if (dpath_ctrl.a_en) begin
      a_reg <= a_next;
    end
  end

  always_ff @(posedge clk or posedge clk_reset) begin
    if (clk_reset) begin
      b_reg <= '0;
    end else if (dpath_ctrl.b_en) begin
      b_reg <= b_next;
    end
  end

  //--------------------------------------------------------------------------
  // arithmetic and compare
  //--------------------------------------------------------------------------

  // one subtractor for both the step and the result
  assign sub_out = a_reg - b_reg;

  // done state has b == 0, so a - b is just a
  assign resp = sub_out;

  // comparisons made once here, fsm only reads the flags
  assign dpath_status.a_lt_b = (a_reg < b_reg);
  assign dpath_status.b_zero = (b_reg == '0);

  //--------------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------------

  // subtract step only taken when a >= b, so a never wraps
  a_no_wrap: assert property (@(posedge clk) disable iff (clk_reset)
    (dpath_ctrl.a_en && dpath_ctrl.a_sel == A_SEL_SUB) |-> !dpath_status.a_lt_b);

endmodule

/* src/gcd_pkg.sv */
/* shared types and constants for the gcd unit
   imported by wildcard into every module header and by the testbench */

package gcd_pkg;

  //--------------------------------------------------------------------------
  // widths and message types
  //--------------------------------------------------------------------------

  // operand and result width
  localparam int GCD_W = 16;

  // one operand or one result
  typedef logic [GCD_W-1:0] gcd_operand_t;

  // request message, a sits in the upper half
  typedef struct packed {
    gcd_operand_t a;
    gcd_operand_t b;
  } gcd_req_t;

  // response message is just the result
  typedef gcd_operand_t gcd_resp_t;

  //--------------------------------------------------------------------------
  // datapath mux selects
  //--------------------------------------------------------------------------

  // next value of register a
  typedef logic [1:0] gcd_a_sel_t;

  localparam gcd_a_sel_t A_SEL_IN  = 2'd0;   // operand from the request
  localparam gcd_a_sel_t A_SEL_SUB = 2'd1;   // a - b
  localparam gcd_a_sel_t A_SEL_B   = 2'd2;   // swap in b

  // next value of register b
  typedef logic [0:0] gcd_b_sel_t;

  localparam gcd_b_sel_t B_SEL_A  = 1'b0;    // swap in a
  localparam gcd_b_sel_t B_SEL_IN = 1'b1;    // operand from the request

  //--------------------------------------------------------------------------
  // control and status between FSM and datapath
  //--------------------------------------------------------------------------

  // fsm to datapath, 5 bits
  typedef struct packed {
    gcd_a_sel_t a_sel;
    logic       a_en;
    gcd_b_sel_t b_sel;
    logic       b_en;
  } gcd_dpath_ctrl_t;

  // datapath to fsm, 2 bits
  typedef struct packed {
    logic a_lt_b;
    logic b_zero;
  } gcd_dpath_status_t;

  // control fsm state
  typedef enum logic [1:0] {
    GCD_IDLE = 2'd0,
    GCD_CALC = 2'd1,
    GCD_DONE = 2'd2
  } gcd_state_e;

endpackage

/* src/gcd_unit.sv */
/* top of the gcd unit, one request in flight at a time
   valid/ready request of two operands in, valid/ready result out */

`timescale 1ns/100ps

module gcd_unit
  import gcd_pkg::*;
(
  input  logic      clk,
  input  logic      clk_reset,

  // request from producer
  input  logic      req_val,
  output logic      req_rdy,
  input  gcd_req_t  req,

  // response to consumer
  output logic      resp_val,
  input  logic      resp_rdy,
  output gcd_resp_t resp
);

  // fsm controls and datapath flags
  gcd_dpath_ctrl_t   dpath_ctrl;
  gcd_dpath_status_t dpath_status;

  //--------------------------------------------------------------------------
  // control
  //--------------------------------------------------------------------------

  gcd_ctrl ctrl (
    .clk          (clk),
    .clk_reset    (clk_reset),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy),
    .dpath_status (dpath_status),
    .dpath_ctrl   (dpath_ctrl)
  );

  //--------------------------------------------------------------------------
  // datapath
  //--------------------------------------------------------------------------

  // operands go straight in, result straight out
  gcd_dpath dpath (
    .clk          (clk),
    .clk_reset    (clk_reset),
    .req          (req),
    .dpath_ctrl   (dpath_ctrl),
    .dpath_status (dpath_status),
    .resp         (resp)
  );

endmodule
